// ==== project.f ====
+incdir+common
common/lsu_pkg.sv
lsu_request/lsu_request.sv
hdl/lsu_txn_tracker.sv
lsu_rdata_align/lsu_rdata_align.sv
hdl/lsu_top.sv
tests/tb_clk_gen.sv
tests/tb_lsu.sv

// ==== Makefile ====
# Verilator simulation of the LSU testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_lsu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module tb_lsu;

  logic clk, rst_n, kill_ex, halt_ex, halt_wb, block_addr, bus_gnt, bus_rvalid, bus_valid;
  logic err_wb, misaligned, ready_ex, ready_wb, busy, resp_hold, err_next, resp_err;
  lsu_pkg::ex_req_t   ex_req;
  lsu_pkg::bus_req_t  bus_req;
  lsu_pkg::bus_resp_t bus_resp;
  logic [31:0] rdata, addr_wb, acc_addr, acc_wdata, resp_data;
  logic [3:0]  acc_be;
  logic        acc_we;
  logic [31:0] mem [0:63];                 // Word memory behind the bus
  int          errors, outstanding, accepts, gnt_mode, i;
  int          q_delay [$];                // Pending responses, in order
  logic [31:0] q_addr [$];
  logic        q_err [$];

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top i_lsu_top
  (
    .clk(clk), .rst_n(rst_n), .ex_req_i(ex_req), .kill_ex_i(kill_ex), .halt_ex_i(halt_ex),
    .halt_wb_i(halt_wb), .block_addr_i(block_addr), .bus_req_o(bus_req),
    .bus_valid_o(bus_valid), .bus_gnt_i(bus_gnt), .bus_rvalid_i(bus_rvalid),
    .bus_resp_i(bus_resp), .rdata_o(rdata), .err_wb_o(err_wb), .addr_wb_o(addr_wb),
    .misaligned_o(misaligned), .ready_ex_o(ready_ex), .ready_wb_o(ready_wb), .busy_o(busy)
  );

  task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("error %s: got %h, expected %h", name, got, exp);
  endtask

  task automatic check_failed(string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic timeout_abort(string what);
    $display("timeout while waiting for %s", what);
    $display("errors: %0d", errors);
    $display("FAIL: see errors above");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Reference rules
  function automatic logic [3:0] exp_be(logic [1:0] size, logic [1:0] off, logic second);
    int         nbytes, first, last;
    logic [3:0] be;
    nbytes = (size == 2'd0) ? 1 : ((size == 2'd1) ? 2 : 4);
    first  = second ? 0 : int'(off);
    last   = int'(off) + nbytes - 1 - (second ? 4 : 0);   // Lanes past 3 go to the next word
    be     = '0;
    for (int b = 0; b < 4; b++)
      be[b] = (b >= first) && (b <= last);
    return be;
  endfunction

  function automatic logic [31:0] rot_left(logic [31:0] w, logic [1:0] n);
    logic [63:0] both;
    both = {w, w} << (8 * n);                            // Upper word is the rotated one
    return both[63:32];
  endfunction

  function automatic logic [31:0] exp_load(logic [1:0] size, logic sext, logic [1:0] off,
                                           logic [31:0] lo, logic [31:0] hi);
    logic [63:0] pair;
    pair = {hi, lo} >> (8 * off);                        // Bytes from the access address up
    if (size == 2'd0)
      return {{24{sext & pair[7]}}, pair[7:0]};
    if (size == 2'd1)
      return {{16{sext & pair[15]}}, pair[15:0]};
    return pair[31:0];
  endfunction

  function automatic logic exp_mis(logic [1:0] size, logic [1:0] off);
    return (size[1] && off != 2'd0) || (size == 2'd1 && off == 2'd3);
  endfunction

  //////////////////////////////////////////////////
  // Bus monitor and memory writes, sampled on the rising edge
  always @(posedge clk)
  begin
    int unsigned r;
    int          d;
    logic        exp_valid, exp_bus_valid, exp_accept, exp_ready_ex, exp_ready_wb, exp_busy;
    if (rst_n)
    begin
      exp_valid     = ex_req.req && !kill_ex;
      exp_bus_valid = exp_valid && outstanding < 2;
      exp_accept    = exp_bus_valid && bus_gnt;
      exp_busy      = outstanding != 0 || exp_bus_valid;
      if (!exp_valid)
        exp_ready_ex = !halt_ex;
      else if (outstanding == 0)
        exp_ready_ex = exp_accept && !halt_ex;
      else if (outstanding == 1)
        exp_ready_ex = exp_accept && bus_rvalid && !halt_ex;  // Accept and response together
      else
        exp_ready_ex = bus_rvalid && !halt_ex;
      exp_ready_wb = (outstanding == 0) ? !halt_wb : (bus_rvalid && !halt_wb);
      assert (bus_valid == exp_bus_valid)
        else value_error("bus_valid_o", 32'(bus_valid), 32'(exp_bus_valid));
      assert (busy == exp_busy) else value_error("busy_o", 32'(busy), 32'(exp_busy));
      assert (ready_ex == exp_ready_ex)
        else value_error("ready_ex_o", 32'(ready_ex), 32'(exp_ready_ex));
      assert (ready_wb == exp_ready_wb)
        else value_error("ready_wb_o", 32'(ready_wb), 32'(exp_ready_wb));
      d = 0;
      if (bus_valid && bus_gnt)
      begin
        r = $urandom;
        q_delay.push_back(1 + int'(r % 3));              // Response 1 to 3 cycles later
        q_addr.push_back(bus_req.addr);
        q_err.push_back(err_next);
        if (bus_req.we)
          for (int b = 0; b < 4; b++)
            if (bus_req.be[b])
              mem[bus_req.addr[7:2]][8*b +: 8] = bus_req.wdata[8*b +: 8];
        d = 1;
        accepts <= accepts + 1;
      end
      outstanding <= outstanding + d - (bus_rvalid ? 1 : 0);
    end
  end

  // Grant and in-order responses, driven on the falling edge
  always @(negedge clk)
  begin
    int unsigned r;
    bus_rvalid = 1'b0;
    bus_resp   = '0;
    if (rst_n && !resp_hold && q_delay.size() > 0)
    begin
      if (q_delay[0] <= 1)
      begin
        bus_rvalid     = 1'b1;
        bus_resp.rdata = mem[q_addr[0][7:2]];
        bus_resp.err   = q_err[0];
        void'(q_delay.pop_front());
        void'(q_addr.pop_front());
        void'(q_err.pop_front());
      end
      else
        q_delay[0] = q_delay[0] - 1;
    end
    r = $urandom;
    case (gnt_mode)
      1:       bus_gnt = 1'b0;                           // Back-pressure
      2:       bus_gnt = 1'b1;
      default: bus_gnt = r[0];
    endcase
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  task automatic drive_req(logic we, logic [1:0] size, logic sext, logic second,
                           logic [31:0] addr, logic [31:0] wdata, logic [1:0] reg_off);
    ex_req            = '0;
    ex_req.req        = 1'b1;
    ex_req.we         = we;
    ex_req.size       = lsu_pkg::size_e'(size);
    ex_req.sign_ext   = sext;
    ex_req.misaligned = second;
    ex_req.useincr    = addr[4];                         // Half of the accesses use op_b
    ex_req.op_a       = addr[4] ? addr - 32'd16 : addr;
    ex_req.op_b       = addr[4] ? 32'd16 : 32'hdead_beef;
    ex_req.wdata      = wdata;
    ex_req.reg_offset = reg_off;
  endtask

  task automatic wait_accept();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < 100 && !seen; n++)
    begin
      @(posedge clk);
      if (bus_valid && bus_gnt)
      begin
        seen      = 1'b1;
        acc_addr  = bus_req.addr;
        acc_we    = bus_req.we;
        acc_be    = bus_req.be;
        acc_wdata = bus_req.wdata;
      end
    end
    if (!seen)
      timeout_abort("a bus grant");
    @(negedge clk);
  endtask

  task automatic wait_resp();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < 100 && !seen; n++)
    begin
      @(posedge clk);
      if (bus_rvalid)
      begin
        seen      = 1'b1;
        resp_data = rdata;                               // Combinational during the pulse
        resp_err  = err_wb;
      end
    end
    if (!seen)
      timeout_abort("a bus response");
    @(negedge clk);
  endtask

  task automatic wait_idle();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < 100 && !seen; n++)
    begin
      @(posedge clk);
      seen = !busy;
    end
    if (!seen)
      timeout_abort("the LSU to go idle");
    @(negedge clk);
  endtask

  // Address and direction of the last accepted transfer
  task automatic check_accept(logic [31:0] exp_addr, logic exp_we);
    assert (acc_addr == exp_addr) else value_error("bus_req_o.addr", acc_addr, exp_addr);
    assert (acc_we == exp_we) else value_error("bus_req_o.we", 32'(acc_we), 32'(exp_we));
  endtask

  task automatic do_store(logic [1:0] size, logic [31:0] addr, logic [31:0] wdata,
                          logic [1:0] reg_off);
    logic [31:0] exp_w, next_addr;
    logic [3:0]  exp_b;
    logic        mis;
    exp_w     = rot_left(wdata, addr[1:0] - reg_off);
    next_addr = addr + 32'd4;
    mis       = exp_mis(size, addr[1:0]);
    drive_req(1'b1, size, 1'b0, 1'b0, addr, wdata, reg_off);
    #1;
    assert (misaligned == mis) else value_error("misaligned_o", 32'(misaligned), 32'(mis));
    wait_accept();
    check_accept(addr, 1'b1);
    exp_b = exp_be(size, addr[1:0], 1'b0);
    assert (acc_be == exp_b) else value_error("bus_req_o.be", 32'(acc_be), 32'(exp_b));
    assert (acc_wdata == exp_w) else value_error("bus_req_o.wdata", acc_wdata, exp_w);
    if (mis)
    begin
      drive_req(1'b1, size, 1'b0, 1'b1, next_addr, wdata, reg_off);
      wait_accept();
      check_accept({next_addr[31:2], 2'b00}, 1'b1);
      exp_b = exp_be(size, addr[1:0], 1'b1);
      assert (acc_be == exp_b) else value_error("bus_req_o.be", 32'(acc_be), 32'(exp_b));
      assert (acc_wdata == exp_w) else value_error("bus_req_o.wdata", acc_wdata, exp_w);
    end
    ex_req = '0;
    wait_idle();
  endtask

  task automatic do_load(logic [1:0] size, logic sext, logic [31:0] addr);
    logic [31:0] exp_r, next_addr;
    logic        mis;
    next_addr = addr + 32'd4;
    exp_r     = exp_load(size, sext, addr[1:0], mem[addr[7:2]], mem[next_addr[7:2]]);
    mis       = exp_mis(size, addr[1:0]);
    drive_req(1'b0, size, sext, 1'b0, addr, 32'h0, 2'd0);
    #1;
    assert (misaligned == mis) else value_error("misaligned_o", 32'(misaligned), 32'(mis));
    wait_accept();
    check_accept(addr, 1'b0);
    if (mis)
    begin
      drive_req(1'b0, size, sext, 1'b1, next_addr, 32'h0, 2'd0);
      ex_req.req = 1'b0;                                 // Second phase waits for the first word
      wait_resp();
      ex_req.req = 1'b1;
      wait_accept();
      check_accept({next_addr[31:2], 2'b00}, 1'b0);
    end
    ex_req = '0;
    wait_resp();
    assert (resp_data == exp_r) else value_error("rdata_o", resp_data, exp_r);
    assert (!resp_err) else value_error("err_wb_o", 32'(resp_err), 32'h0);
    #1;                                                  // Pulse over, held word shows
    assert (rdata == exp_r) else value_error("rdata_o", rdata, exp_r);
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  initial
  begin
    int          acc_before;
    logic [31:0] w;
    void'($urandom(70582));
    errors      = 0;
    outstanding = 0;
    accepts     = 0;
    gnt_mode    = 0;
    ex_req      = '0;
    kill_ex     = 1'b0;
    halt_ex     = 1'b0;
    halt_wb     = 1'b0;
    block_addr  = 1'b0;
    bus_gnt     = 1'b0;
    bus_rvalid  = 1'b0;
    bus_resp    = '0;
    resp_hold   = 1'b0;
    err_next    = 1'b0;
    for (i = 0; i < 64; i++)
      mem[i] = $urandom;
    for (i = 0; i < 40 && rst_n !== 1'b1; i++)
      @(negedge clk);
    if (rst_n !== 1'b1)
      timeout_abort("reset release");
    @(negedge clk);

    // Stores of every size and offset
    for (int s = 0; s < 3; s++)
      for (int o = 0; o < 4; o++)
      begin
        w = $urandom;
        do_store(2'(s), 32'(16 * s + 4 * o + o), $urandom, w[1:0]);
      end

    // Loads, aligned and split, with and without sign extension
    for (int s = 0; s < 3; s++)
      for (int e = 0; e < 2; e++)
        for (int o = 0; o < 4; o++)
          do_load(2'(s), e[0], 32'(128 + 16 * s + 8 * e + o));

    // Depth limit under back-pressure
    gnt_mode = 1;
    drive_req(1'b0, 2'd2, 1'b0, 1'b0, 32'h10, 32'h0, 2'd0);
    repeat (3) @(negedge clk);
    assert (bus_valid) else value_error("bus_valid_o", 32'(bus_valid), 32'h1);
    resp_hold = 1'b1;
    gnt_mode  = 2;
    for (i = 0; i < 20 && bus_valid; i++)
      @(negedge clk);
    assert (!bus_valid) else value_error("bus_valid_o", 32'(bus_valid), 32'h0);
    assert (outstanding == 2) else check_failed("depth test did not reach two outstanding");
    ex_req    = '0;
    resp_hold = 1'b0;
    gnt_mode  = 0;
    wait_idle();

    // Bus error and captured address
    err_next = 1'b1;
    drive_req(1'b0, 2'd2, 1'b0, 1'b0, 32'h40, 32'h0, 2'd0);
    wait_accept();
    err_next = 1'b0;
    ex_req   = '0;
    assert (addr_wb == 32'h40) else value_error("addr_wb_o", addr_wb, 32'h40);
    wait_resp();
    assert (resp_err) else value_error("err_wb_o", 32'(resp_err), 32'h1);
    block_addr = 1'b1;                                   // Address must stay frozen
    drive_req(1'b0, 2'd2, 1'b0, 1'b0, 32'h84, 32'h0, 2'd0);
    wait_accept();
    ex_req = '0;
    assert (addr_wb == 32'h40) else value_error("addr_wb_o", addr_wb, 32'h40);
    wait_resp();
    assert (!resp_err) else value_error("err_wb_o", 32'(resp_err), 32'h0);
    block_addr = 1'b0;

    // Kill and halt
    acc_before = accepts;
    gnt_mode   = 2;
    kill_ex    = 1'b1;
    drive_req(1'b0, 2'd2, 1'b0, 1'b0, 32'h20, 32'h0, 2'd0);
    repeat (6) @(negedge clk);
    assert (accepts == acc_before) else check_failed("a killed request reached the bus");
    kill_ex = 1'b0;
    ex_req  = '0;
    halt_ex = 1'b1;
    halt_wb = 1'b1;
    @(negedge clk);                                      // Halted with no request
    drive_req(1'b0, 2'd0, 1'b0, 1'b0, 32'h24, 32'h0, 2'd0);
    repeat (6) @(negedge clk);                           // Ready checked by the monitor
    ex_req   = '0;
    halt_ex  = 1'b0;
    halt_wb  = 1'b0;
    gnt_mode = 0;
    wait_idle();

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

// Clock and reset source for the LSU testbench
module tb_clk_gen
(
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;                  // Reset held from time zero
  end

  always #5 clk_o = ~clk_o;          // 10 ns period

  initial
  begin
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;                  // Release away from the active edge
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_top
(
  input  wire                         clk,
  input  wire                         rst_n,

  // EX stage request and pipeline control
  input  lsu_pkg::ex_req_t            ex_req_i,
  input  wire                         kill_ex_i,
  input  wire                         halt_ex_i,
  input  wire                         halt_wb_i,
  input  wire                         block_addr_i,   // Freeze addr_wb_o after a bus error

  // Data bus
  output lsu_pkg::bus_req_t           bus_req_o,
  output logic                        bus_valid_o,
  input  wire                         bus_gnt_i,
  input  wire                         bus_rvalid_i,
  input  lsu_pkg::bus_resp_t          bus_resp_i,

  // Results towards the pipeline
  output logic [`LSU_DATA_W-1:0]      rdata_o,
  output logic                        err_wb_o,
  output logic [`LSU_DATA_W-1:0]      addr_wb_o,
  output logic                        misaligned_o,   // Controller issues the second phase
  output logic                        ready_ex_o,
  output logic                        ready_wb_o,
  output logic                        busy_o
);

  logic              req_valid;                       // Request not killed
  logic              first_part;                      // Split access not yet complete
  logic              ctrl_update;                     // EX moves on to WB
  lsu_pkg::wb_ctrl_t wb_ctrl;

  //////////////////////////////////////////////////
  // Input side
  lsu_request i_request
  (
    .ex_req_i     ( ex_req_i     ),
    .kill_ex_i    ( kill_ex_i    ),
    .req_valid_o  ( req_valid    ),
    .bus_req_o    ( bus_req_o    ),
    .wb_ctrl_o    ( wb_ctrl      ),
    .misaligned_o ( misaligned_o ),
    .first_part_o ( first_part   )
  );

  //////////////////////////////////////////////////
  // Outstanding transfers and handshakes
  lsu_txn_tracker i_tracker
  (
    .clk           ( clk          ),
    .rst_n         ( rst_n        ),
    .req_valid_i   ( req_valid    ),
    .bus_req_i     ( bus_req_o    ),
    .bus_gnt_i     ( bus_gnt_i    ),
    .bus_rvalid_i  ( bus_rvalid_i ),
    .halt_ex_i     ( halt_ex_i    ),
    .halt_wb_i     ( halt_wb_i    ),
    .block_addr_i  ( block_addr_i ),
    .bus_valid_o   ( bus_valid_o  ),
    .ctrl_update_o ( ctrl_update  ),
    .ready_ex_o    ( ready_ex_o   ),
    .ready_wb_o    ( ready_wb_o   ),
    .busy_o        ( busy_o       ),
    .addr_wb_o     ( addr_wb_o    )
  );

  //////////////////////////////////////////////////
  // Output side
  lsu_rdata_align i_rdata_align
  (
    .clk           ( clk          ),
    .rst_n         ( rst_n        ),
    .ctrl_update_i ( ctrl_update  ),
    .wb_ctrl_i     ( wb_ctrl      ),
    .first_part_i  ( first_part   ),
    .bus_rvalid_i  ( bus_rvalid_i ),
    .bus_resp_i    ( bus_resp_i   ),
    .rdata_o       ( rdata_o      ),
    .err_wb_o      ( err_wb_o     )
  );

endmodule

`default_nettype wire

// ==== lsu_rdata_align/lsu_rdata_align.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_rdata_align
(
  input  wire                    clk,
  input  wire                    rst_n,

  input  wire                    ctrl_update_i,
  input  lsu_pkg::wb_ctrl_t      wb_ctrl_i,
  input  wire                    first_part_i,   // Keep the raw word for splicing
  input  wire                    bus_rvalid_i,
  input  lsu_pkg::bus_resp_t     bus_resp_i,

  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   err_wb_o
);

  lsu_pkg::wb_ctrl_t      wb_ctrl_q;
  lsu_pkg::rdata_view_u   resp;
  logic [`LSU_DATA_W-1:0] rdata_q;               // Held data or first half of split load
  logic [7:0]             byte_sel;
  logic [15:0]            half_sel;
  logic [`LSU_DATA_W-1:0] word_sel;
  logic [`LSU_DATA_W-1:0] rdata_ext;

  // WB control follows the access into the WB stage
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      wb_ctrl_q <= '0;
    else if (ctrl_update_i)
      wb_ctrl_q <= wb_ctrl_i;
  end

  assign resp = bus_resp_i.rdata;

  //////////////////////////////////////////////////
  // Lane selection
  assign byte_sel = resp.bytes[wb_ctrl_q.offset];

  always_comb
  begin
    case (wb_ctrl_q.offset)
      2'd0:    half_sel = resp.halves[0];
      2'd1:    half_sel = {resp.bytes[2], resp.bytes[1]};
      2'd2:    half_sel = resp.halves[1];
      default: half_sel = {resp.bytes[0], rdata_q[31:24]};   // Spliced with first part
    endcase
  end

  // Misaligned words take the upper bytes of the first response
  always_comb
  begin
    case (wb_ctrl_q.offset)
      2'd0:    word_sel = resp;
      2'd1:    word_sel = {resp.bytes[0], rdata_q[31:8]};
      2'd2:    word_sel = {resp.halves[0], rdata_q[31:16]};
      default: word_sel = {resp.bytes[2], resp.bytes[1], resp.bytes[0], rdata_q[31:24]};
    endcase
  end

  // Sign or zero extension
  always_comb
  begin
    case (wb_ctrl_q.size)
      lsu_pkg::BYTE: rdata_ext = {{24{wb_ctrl_q.sign_ext && byte_sel[7]}}, byte_sel};
      lsu_pkg::HALF: rdata_ext = {{16{wb_ctrl_q.sign_ext && half_sel[15]}}, half_sel};
      default:       rdata_ext = word_sel;
    endcase
  end

  //////////////////////////////////////////////////
  // Held read data
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (bus_rvalid_i && !wb_ctrl_q.we)      // Loads only
      rdata_q <= first_part_i ? resp : rdata_ext;
  end

  assign rdata_o  = bus_rvalid_i ? rdata_ext : rdata_q;
  assign err_wb_o = bus_rvalid_i && bus_resp_i.err;    // Error valid only with response

endmodule

`default_nettype wire

// ==== hdl/lsu_txn_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_txn_tracker
(
  input  wire                    clk,
  input  wire                    rst_n,

  input  wire                    req_valid_i,
  input  lsu_pkg::bus_req_t      bus_req_i,
  input  wire                    bus_gnt_i,
  input  wire                    bus_rvalid_i,
  input  wire                    halt_ex_i,
  input  wire                    halt_wb_i,
  input  wire                    block_addr_i,

  output logic                   bus_valid_o,
  output logic                   ctrl_update_o,
  output logic                   ready_ex_o,
  output logic                   ready_wb_o,
  output logic                   busy_o,
  output logic [`LSU_DATA_W-1:0] addr_wb_o
);

  logic [`LSU_CNT_W-1:0] cnt_q;              // Outstanding transfers
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  accept;             // Transfer granted this cycle

  // Hold the request back while the bus already has DEPTH transfers pending
  assign bus_valid_o = req_valid_i && (cnt_q < `LSU_CNT_W'(`LSU_DEPTH));
  assign accept      = bus_valid_o && bus_gnt_i;

  //////////////////////////////////////////////////
  // Outstanding transaction counter
  always_comb
  begin
    case ({accept, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;                // Idle or accept with response
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  // EX and WB advance together once WB holds a transfer
  assign ready_ex_o = !req_valid_i      ? !halt_ex_i :
                      (cnt_q == 2'd0)   ? accept && !halt_ex_i :
                      (cnt_q == 2'd1)   ? accept && bus_rvalid_i && !halt_ex_i :
                                          bus_rvalid_i && !halt_ex_i;

  assign ready_wb_o    = (cnt_q == 2'd0) ? !halt_wb_i : (bus_rvalid_i && !halt_wb_i);
  assign ctrl_update_o = ready_ex_o && req_valid_i;  // Load WB control
  assign busy_o        = (cnt_q != 2'd0) || bus_valid_o;

  //////////////////////////////////////////////////
  // Bus error address for the WB stage
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      addr_wb_o <= '0;
    else if (accept && !block_addr_i)        // Frozen by controller after an error
      addr_wb_o <= bus_req_i.addr;
  end

endmodule

`default_nettype wire

// ==== lsu_request/lsu_request.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_request
(
  input  lsu_pkg::ex_req_t  ex_req_i,
  input  wire               kill_ex_i,

  output logic              req_valid_o,
  output lsu_pkg::bus_req_t bus_req_o,
  output lsu_pkg::wb_ctrl_t wb_ctrl_o,
  output logic              misaligned_o,
  output logic              first_part_o
);

  logic [`LSU_DATA_W-1:0] addr;             // Effective address
  logic [1:0]             offset;           // Byte offset within the word
  logic [1:0]             wdata_rot;        // Store data rotation in bytes
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_DATA_W-1:0] wdata;
  logic                   second_phase;

  assign second_phase = ex_req_i.misaligned;
  assign req_valid_o  = ex_req_i.req && !kill_ex_i;  // Kill blocks the request

  // Post-increment style accesses add the offset operand
  assign addr   = ex_req_i.useincr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;
  assign offset = addr[1:0];

  //////////////////////////////////////////////////
  // Byte enables
  always_comb
  begin
    case (ex_req_i.size)
      lsu_pkg::BYTE:
      begin
        be = 4'b0001 << offset;                        // Single lane
      end
      lsu_pkg::HALF:
      begin
        if (second_phase)
          be = 4'b0001;                                // Upper byte lands in lane 0
        else
          be = 4'b0011 << offset;                      // Lane 3 only at offset 3
      end
      default:
      begin
        if (second_phase)
          be = (4'b0001 << offset) - 4'b0001;          // Lanes below the offset
        else
          be = 4'b1111 << offset;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Store data rotation
  assign wdata_rot = offset - ex_req_i.reg_offset;

  always_comb
  begin
    case (wdata_rot)
      2'd0:    wdata = ex_req_i.wdata;
      2'd1:    wdata = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'd2:    wdata = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata = {ex_req_i.wdata[7:0],  ex_req_i.wdata[31:8]};
    endcase
  end

  //////////////////////////////////////////////////
  // Misalignment detection
  // Only the first phase can be misaligned, the second one is word aligned
  always_comb
  begin
    misaligned_o = 1'b0;
    if (req_valid_o && !second_phase)
    begin
      case (ex_req_i.size)
        lsu_pkg::BYTE: misaligned_o = 1'b0;
        lsu_pkg::HALF: misaligned_o = (offset == 2'b11);  // Crosses into next word
        default:       misaligned_o = (offset != 2'b00);
      endcase
    end
  end

  assign first_part_o = misaligned_o || second_phase;

  // Second phase goes to the next word, so drop the offset
  assign bus_req_o.addr  = second_phase ? {addr[`LSU_DATA_W-1:2], 2'b00} : addr;
  assign bus_req_o.we    = ex_req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata;

  // Control forwarded to WB for read alignment
  assign wb_ctrl_o.size     = ex_req_i.size;
  assign wb_ctrl_o.offset   = offset;                 // Offset of the original address
  assign wb_ctrl_o.sign_ext = ex_req_i.sign_ext;
  assign wb_ctrl_o.we       = ex_req_i.we;

endmodule

`default_nettype wire

// ==== common/lsu_pkg.sv ====
`default_nettype none
`include "lsu_settings.svh"

package lsu_pkg;

  // Access size as encoded by the decoder
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10                          // 2'b11 is also handled as a word
  } size_e;

  // Load/store request from the EX stage
  typedef struct packed {
    logic                   req;          // LSU access strobe
    logic                   we;           // Store when set
    size_e                  size;
    logic                   sign_ext;     // Sign extend loaded data
    logic                   misaligned;   // Second phase of a split access
    logic                   useincr;      // Address is op_a + op_b
    logic [`LSU_DATA_W-1:0] op_a;
    logic [`LSU_DATA_W-1:0] op_b;
    logic [`LSU_DATA_W-1:0] wdata;        // Store data from the register file
    logic [1:0]             reg_offset;   // Byte offset of data in the register
  } ex_req_t;

  // Data bus request
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;
  } bus_req_t;

  // Data bus response
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   err;
  } bus_resp_t;

  // Control kept for the WB stage until the response arrives
  typedef struct packed {
    size_e      size;
    logic [1:0] offset;                   // Byte offset of the access address
    logic       sign_ext;
    logic       we;
  } wb_ctrl_t;

  // Response word seen as byte lanes or as halfwords
  typedef union packed {
    logic [`LSU_BE_W-1:0][7:0]    bytes;
    logic [`LSU_BE_W/2-1:0][15:0] halves;
  } rdata_view_u;

endpackage

`default_nettype wire

// ==== common/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Data and address width of the LSU and its bus
`define LSU_DATA_W 32

// One enable per byte lane
`define LSU_BE_W 4

// Outstanding bus transactions allowed at once
`define LSU_DEPTH 2

// Width of the outstanding transaction counter
// Must hold the value LSU_DEPTH
`define LSU_CNT_W 2

`endif
